/* hdl/video_pkg.sv */
`default_nettype none

package video_pkg;

  //////////////////////////////////////////////////////////////////////
  // pixel stream types
  //////////////////////////////////////////////////////////////////////

  typedef logic [11:0] coord_t;   // screen coordinate, 12 bits
  typedef logic [11:0] rgb_t;     // 4:4:4 colour

  // one pixel of the video stream as it moves down the pipeline
  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    rgb_t   rgb;
  } pixel_t;

  //////////////////////////////////////////////////////////////////////
  // game field geometry, all edges inclusive
  //////////////////////////////////////////////////////////////////////

  localparam coord_t FIELD_TOP    = 12'd317;
  localparam coord_t FIELD_BOTTOM = 12'd617;
  localparam coord_t FIELD_LEFT   = 12'd361;
  localparam coord_t FIELD_RIGHT  = 12'd661;

  localparam rgb_t WALL_RGB = 12'hfff;   // laser walls are plain white

  // true when the pixel lies in the 300x300 field, border included
  function automatic logic in_field(pixel_t p);
    logic in_h;
    logic in_v;
    in_h = (p.hcount >= FIELD_LEFT) && (p.hcount <= FIELD_RIGHT);
    in_v = (p.vcount >= FIELD_TOP) && (p.vcount <= FIELD_BOTTOM);
    return in_h && in_v;
  endfunction

endpackage

`default_nettype wire

/* hdl/obstacle_pkg.sv */
`default_nettype none

package obstacle_pkg;

  // sequencer phases; the seven motion phases sit in one contiguous range
  typedef enum logic [3:0] {
    IDLE            = 4'd0,
    CLOSE_IN        = 4'd1,
    SHIFT_RIGHT_UP  = 4'd2,
    SHIFT_DOWN      = 4'd3,
    SHIFT_LEFT_UP   = 4'd4,
    SQUEEZE         = 4'd5,
    SHIFT_DOWN_MID  = 4'd6,
    SHIFT_RIGHT_MID = 4'd7,
    HOLD_ACK        = 4'd8,   // run finished, ack held until req drops
    WAIT_DROP       = 4'd9    // aborted, waiting for req to drop
  } phase_e;

  // current hole, also published for collision logic
  typedef struct packed {
    video_pkg::coord_t top;
    video_pkg::coord_t bottom;
    video_pkg::coord_t left;
    video_pkg::coord_t right;
  } hole_t;

  // hole at the start of a run, one pixel inside the field
  localparam video_pkg::coord_t HOLE_START_TOP    = 12'd318;
  localparam video_pkg::coord_t HOLE_START_BOTTOM = 12'd616;
  localparam video_pkg::coord_t HOLE_START_LEFT   = 12'd362;
  localparam video_pkg::coord_t HOLE_START_RIGHT  = 12'd660;

  localparam hole_t HOLE_START = '{top:    HOLE_START_TOP,
                                   bottom: HOLE_START_BOTTOM,
                                   left:   HOLE_START_LEFT,
                                   right:  HOLE_START_RIGHT};

  function automatic logic is_motion(phase_e p);
    return p inside {[CLOSE_IN:SHIFT_RIGHT_MID]};
  endfunction

endpackage

`default_nettype wire

/* hdl/step_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module step_timer #(
  parameter logic [31:0] STEP_CYCLES  = 32'd3_200_000,
  parameter logic [31:0] DWELL_CYCLES = 32'd32_000_000
) (
  input  wire  pclk,
  input  wire  rst,
  input  wire  run,        // sequencer is in a motion phase
  input  wire  fast,       // half-length step period
  input  wire  settle,     // end condition of the phase holds
  input  wire  restart,    // phase is about to change
  output logic step_tick,
  output logic dwell_done
);

  localparam logic [31:0] FAST_CYCLES = STEP_CYCLES / 2;

  logic [31:0] step_cnt;
  logic [31:0] step_last;
  logic [31:0] dwell_cnt;

  //////////////////////////////////////////////////////////////////////
  // step counter
  //////////////////////////////////////////////////////////////////////

  assign step_last = fast ? FAST_CYCLES - 32'd1 : STEP_CYCLES - 32'd1;
  assign step_tick = run && (step_cnt >= step_last);   // one cycle per period

  always_ff @(posedge pclk) begin
    if (rst || restart || !run) begin
      step_cnt <= '0;
    end else if (step_tick) begin
      step_cnt <= '0;
    end else begin
      step_cnt <= step_cnt + 32'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // dwell counter, counts settled cycles and then holds
  //////////////////////////////////////////////////////////////////////

  assign dwell_done = settle && (dwell_cnt >= DWELL_CYCLES);

  always_ff @(posedge pclk) begin
    if (rst || restart || !settle) begin
      dwell_cnt <= '0;
    end else if (!dwell_done) begin
      dwell_cnt <= dwell_cnt + 32'd1;   // saturates at DWELL_CYCLES
    end
  end

endmodule

`default_nettype wire

/* hdl/hole_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module hole_sequencer #(
  parameter logic [31:0] STEP_CYCLES  = 32'd3_200_000,
  parameter logic [31:0] DWELL_CYCLES = 32'd32_000_000
) (
  input  wire                 pclk,
  input  wire                 rst,
  input  wire                 start_req,
  input  wire                 abort,
  output logic                start_ack,
  output logic                working,
  output obstacle_pkg::hole_t hole
);

  // end thresholds of the motion phases
  localparam video_pkg::coord_t CLOSE_IN_END  = video_pkg::FIELD_TOP + 12'd125;
  localparam video_pkg::coord_t SQUEEZE_END   = video_pkg::FIELD_LEFT + 12'd40;
  localparam video_pkg::coord_t DOWN_MID_END  = video_pkg::FIELD_TOP + 12'd130;
  localparam video_pkg::coord_t RIGHT_MID_END = video_pkg::FIELD_LEFT + 12'd130;

  // edge deltas, two's complement
  localparam logic [1:0] KEEP = 2'b00;
  localparam logic [1:0] INC  = 2'b01;
  localparam logic [1:0] DEC  = 2'b11;

  typedef struct packed {
    logic [1:0] top;
    logic [1:0] bottom;
    logic [1:0] left;
    logic [1:0] right;
  } delta_t;

  obstacle_pkg::phase_e phase;
  obstacle_pkg::phase_e phase_nxt;
  obstacle_pkg::phase_e succ;
  obstacle_pkg::hole_t  hole_nxt;
  delta_t               delta;
  logic                 run;
  logic                 fast;
  logic                 settle;
  logic                 restart;
  logic                 step_tick;
  logic                 dwell_done;

  function automatic video_pkg::coord_t move_edge(video_pkg::coord_t e, logic [1:0] d);
    return e + {{10{d[1]}}, d};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // per-phase motion rules
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fast   = 1'b0;
    settle = 1'b0;
    delta  = '{KEEP, KEEP, KEEP, KEEP};
    succ   = obstacle_pkg::HOLD_ACK;
    case (phase)
      obstacle_pkg::CLOSE_IN: begin   // shrink towards the middle
        settle = hole.top >= CLOSE_IN_END;
        delta  = '{top: INC, bottom: DEC, left: INC, right: DEC};
        succ   = obstacle_pkg::SHIFT_RIGHT_UP;
      end
      obstacle_pkg::SHIFT_RIGHT_UP: begin
        settle = hole.right >= video_pkg::FIELD_RIGHT;
        delta  = '{top: DEC, bottom: DEC, left: INC, right: INC};
        succ   = obstacle_pkg::SHIFT_DOWN;
      end
      obstacle_pkg::SHIFT_DOWN: begin
        settle = hole.bottom >= video_pkg::FIELD_BOTTOM;
        delta  = '{top: INC, bottom: INC, left: KEEP, right: KEEP};
        succ   = obstacle_pkg::SHIFT_LEFT_UP;
      end
      obstacle_pkg::SHIFT_LEFT_UP: begin
        fast   = 1'b1;
        settle = hole.top <= video_pkg::FIELD_TOP;
        delta  = '{top: DEC, bottom: DEC, left: DEC, right: DEC};
        succ   = obstacle_pkg::SQUEEZE;
      end
      obstacle_pkg::SQUEEZE: begin   // top-left corner stays put
        settle = hole.right <= SQUEEZE_END;
        delta  = '{top: KEEP, bottom: DEC, left: KEEP, right: DEC};
        succ   = obstacle_pkg::SHIFT_DOWN_MID;
      end
      obstacle_pkg::SHIFT_DOWN_MID: begin
        fast   = 1'b1;
        settle = hole.top >= DOWN_MID_END;
        delta  = '{top: INC, bottom: INC, left: KEEP, right: KEEP};
        succ   = obstacle_pkg::SHIFT_RIGHT_MID;
      end
      obstacle_pkg::SHIFT_RIGHT_MID: begin
        fast   = 1'b1;
        settle = hole.left >= RIGHT_MID_END;
        delta  = '{top: KEEP, bottom: KEEP, left: INC, right: INC};
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // FSM next state and handshake
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    phase_nxt = phase;
    hole_nxt  = hole;
    case (phase)
      obstacle_pkg::IDLE: begin
        if (start_req) begin
          phase_nxt = obstacle_pkg::CLOSE_IN;
          hole_nxt  = obstacle_pkg::HOLE_START;
        end
      end
      obstacle_pkg::HOLD_ACK, obstacle_pkg::WAIT_DROP: begin
        if (!start_req) phase_nxt = obstacle_pkg::IDLE;   // four-phase release
      end
      default: begin
        if (abort) begin
          phase_nxt = obstacle_pkg::WAIT_DROP;
        end else if (dwell_done) begin
          phase_nxt = succ;
        end else if (step_tick && !settle) begin
          hole_nxt.top    = move_edge(hole.top, delta.top);
          hole_nxt.bottom = move_edge(hole.bottom, delta.bottom);
          hole_nxt.left   = move_edge(hole.left, delta.left);
          hole_nxt.right  = move_edge(hole.right, delta.right);
        end
      end
    endcase
  end

  assign run     = obstacle_pkg::is_motion(phase);
  assign restart = phase_nxt != phase;   // timers start fresh in each phase

  always_ff @(posedge pclk) begin
    if (rst) begin
      phase     <= obstacle_pkg::IDLE;
      hole      <= '0;
      start_ack <= 1'b0;
      working   <= 1'b0;
    end else begin
      phase     <= phase_nxt;
      hole      <= hole_nxt;
      start_ack <= phase_nxt == obstacle_pkg::HOLD_ACK;
      working   <= obstacle_pkg::is_motion(phase_nxt);
    end
  end

  step_timer #(
    .STEP_CYCLES  (STEP_CYCLES),
    .DWELL_CYCLES (DWELL_CYCLES)
  ) u_step_timer (
    .pclk       (pclk),
    .rst        (rst),
    .run        (run),
    .fast       (fast),
    .settle     (settle),
    .restart    (restart),
    .step_tick  (step_tick),
    .dwell_done (dwell_done)
  );

endmodule

`default_nettype wire

/* hdl/wall_overlay.sv */
`timescale 1ns/1ps
`default_nettype none

module wall_overlay (
  input  wire                      pclk,
  input  wire                      rst,
  input  wire                      working,
  input  wire obstacle_pkg::hole_t hole,
  input  wire video_pkg::pixel_t   pix_in,
  output video_pkg::pixel_t        pix_out
);

  // one flag per wall band around the hole
  typedef struct packed {
    logic top;
    logic bottom;
    logic left;
    logic right;
  } band_t;

  video_pkg::pixel_t s1_pix;
  band_t             s1_band;
  logic              s1_live;   // obstacle active and pixel in the field

  //////////////////////////////////////////////////////////////////////
  // stage 1: field test and band compare against the current hole
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge pclk) begin
    if (rst) begin
      s1_live <= 1'b0;
    end else begin
      s1_live <= working && video_pkg::in_field(pix_in);
    end
  end

  always_ff @(posedge pclk) begin
    s1_pix         <= pix_in;
    s1_band.top    <= pix_in.vcount <= hole.top;
    s1_band.bottom <= pix_in.vcount >= hole.bottom;
    s1_band.left   <= pix_in.hcount <= hole.left;
    s1_band.right  <= pix_in.hcount >= hole.right;
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2: colour select
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge pclk) begin
    pix_out <= s1_pix;
    if (s1_live && (|s1_band)) begin
      pix_out.rgb <= video_pkg::WALL_RGB;   // pixel falls on a wall
    end
  end

endmodule

`default_nettype wire

/* hdl/obstacle_top.sv */
`timescale 1ns/1ps
`default_nettype none

module obstacle_top #(
  parameter logic [31:0] STEP_CYCLES  = 32'd3_200_000,    // slow step period
  parameter logic [31:0] DWELL_CYCLES = 32'd32_000_000    // pause after each phase
) (
  input  wire                      pclk,
  input  wire                      rst,
  input  wire                      start_req,
  input  wire                      abort,
  input  wire video_pkg::pixel_t   pix_in,
  output video_pkg::pixel_t        pix_out,
  output logic                     start_ack,
  output logic                     working,
  output obstacle_pkg::hole_t      hole
);

  // sequencer side branch, runs the hole through its phases
  hole_sequencer #(
    .STEP_CYCLES  (STEP_CYCLES),
    .DWELL_CYCLES (DWELL_CYCLES)
  ) u_hole_sequencer (
    .pclk      (pclk),
    .rst       (rst),
    .start_req (start_req),
    .abort     (abort),
    .start_ack (start_ack),
    .working   (working),
    .hole      (hole)       // same value goes to the port and the overlay
  );

  // pixel path, two cycles from pix_in to pix_out
  wall_overlay u_wall_overlay (
    .pclk    (pclk),
    .rst     (rst),
    .working (working),
    .hole    (hole),
    .pix_in  (pix_in),
    .pix_out (pix_out)
  );

endmodule

`default_nettype wire

/* bench/tb_obstacle.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_obstacle;

  localparam int STEP_CYCLES  = 4;
  localparam int DWELL_CYCLES = 6;
  localparam int TOTAL_STEPS  = 1019;   // 124+125+250+250+10+130+130
  localparam int NUM_TESTS    = 6;
  localparam int NUM_RUNS     = 7;
  localparam int RUN_LIMIT    = TOTAL_STEPS * STEP_CYCLES + 8 * DWELL_CYCLES + 500;
  localparam int CYCLE_LIMIT  =
    (TOTAL_STEPS * STEP_CYCLES + 8 * DWELL_CYCLES + 500 * NUM_TESTS) * NUM_RUNS;

  localparam obstacle_pkg::hole_t FINAL_HOLE =
    '{top: 12'd447, bottom: 12'd487, left: 12'd491, right: 12'd531};

  // edge deltas of the seven motion phases, in sequence order
  localparam int D_TOP[7]    = '{ 1, -1,  1, -1,  0,  1,  0};
  localparam int D_BOTTOM[7] = '{-1, -1,  1, -1, -1,  1,  0};
  localparam int D_LEFT[7]   = '{ 1,  1,  0, -1,  0,  0,  1};
  localparam int D_RIGHT[7]  = '{-1,  1,  0, -1, -1,  0,  1};

  logic                pclk;
  logic                rst = 1'b1;
  logic                start_req = 1'b0;
  logic                abort = 1'b0;
  video_pkg::pixel_t   pix_in = '0;
  video_pkg::pixel_t   pix_out;
  logic                start_ack;
  logic                working;
  obstacle_pkg::hole_t hole;

  int                  err_cnt = 0;
  int                  tests_run = 0;
  int                  tests_ok = 0;
  int                  px_checked = 0;
  int                  wall_cnt = 0;     // pixels whose colour the DUT changed
  int                  walk_idx = 0;     // model phase, 0 is CLOSE_IN
  int                  walk_steps = 0;
  int                  cycles = 0;
  logic                stream_on = 1'b0;
  logic                outside_only = 1'b0;
  logic                prev_working = 1'b0;
  video_pkg::pixel_t   pipe_q[$];        // expected pixels in flight
  video_pkg::pixel_t   sent_q[$];        // input pixels in flight
  video_pkg::pixel_t   exp_pix;
  video_pkg::pixel_t   sent_pix;
  obstacle_pkg::hole_t prev_hole = '0;
  obstacle_pkg::hole_t walk_hole = '0;

  obstacle_top #(
    .STEP_CYCLES  (STEP_CYCLES),
    .DWELL_CYCLES (DWELL_CYCLES)
  ) DUT (
    .pclk      (pclk),
    .rst       (rst),
    .start_req (start_req),
    .abort     (abort),
    .pix_in    (pix_in),
    .pix_out   (pix_out),
    .start_ack (start_ack),
    .working   (working),
    .hole      (hole)
  );

  initial begin
    pclk = 1'b0;
    forever #2 pclk = ~pclk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic video_pkg::pixel_t expected_pixel(video_pkg::pixel_t p, logic w,
                                                       obstacle_pkg::hole_t h);
    logic in_h;
    logic in_v;
    logic band;
    in_h = p.hcount >= video_pkg::FIELD_LEFT && p.hcount <= video_pkg::FIELD_RIGHT;
    in_v = p.vcount >= video_pkg::FIELD_TOP && p.vcount <= video_pkg::FIELD_BOTTOM;
    band = p.vcount <= h.top || p.vcount >= h.bottom || p.hcount >= h.right
           || p.hcount <= h.left;
    if (w && in_h && in_v && band) p.rgb = video_pkg::WALL_RGB;
    return p;
  endfunction

  function automatic logic end_reached(int idx, obstacle_pkg::hole_t h);
    case (idx)
      0: return h.top >= 12'd442;
      1: return h.right >= 12'd661;
      2: return h.bottom >= 12'd617;
      3: return h.top <= 12'd317;
      4: return h.right <= 12'd401;
      5: return h.top >= 12'd447;
      default: return h.left >= 12'd491;
    endcase
  endfunction

  function automatic obstacle_pkg::hole_t step_hole(int idx, obstacle_pkg::hole_t h);
    obstacle_pkg::hole_t n;
    n.top    = 12'(int'(h.top) + D_TOP[idx]);
    n.bottom = 12'(int'(h.bottom) + D_BOTTOM[idx]);
    n.left   = 12'(int'(h.left) + D_LEFT[idx]);
    n.right  = 12'(int'(h.right) + D_RIGHT[idx]);
    return n;
  endfunction

  // random pixel around the field, or strictly outside it
  function automatic video_pkg::pixel_t next_pixel(logic outside);
    video_pkg::pixel_t p;
    p.hcount = 12'(300 + $urandom % 420);
    p.vcount = 12'(260 + $urandom % 420);
    p.rgb    = 12'($urandom);
    if (outside) begin
      case ($urandom % 4)
        0: p.hcount = 12'($urandom % 361);
        1: p.hcount = 12'(662 + $urandom % 400);
        2: p.vcount = 12'($urandom % 317);
        default: p.vcount = 12'(618 + $urandom % 400);
      endcase
    end
    return p;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_pixel(video_pkg::pixel_t got, video_pkg::pixel_t exp, string what);
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_hole(obstacle_pkg::hole_t got, obstacle_pkg::hole_t exp, string what);
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(int got, int exp, string what);
    if (got != exp) begin
      err_cnt++;
      $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // pixel stream and phase walk monitors
  //////////////////////////////////////////////////////////////////////

  initial begin
    forever begin
      @(negedge pclk);
      if (stream_on) begin
        if (pipe_q.size() == 2) begin   // pixel entered two cycles ago
          sent_pix = sent_q.pop_front();
          if (pix_out.rgb !== sent_pix.rgb) wall_cnt++;
          check_pixel(pix_out, pipe_q.pop_front(), "pixel out");
          px_checked++;
        end
        pix_in  = next_pixel(outside_only);
        exp_pix = expected_pixel(pix_in, working, hole);
        sent_q.push_back(pix_in);
        pipe_q.push_back(exp_pix);
      end
    end
  end

  initial begin
    forever begin
      @(negedge pclk);
      if (working && !prev_working) begin
        check_hole(hole, obstacle_pkg::HOLE_START, "hole at run start");
        walk_hole  = hole;
        walk_idx   = 0;
        walk_steps = 0;
      end else if (working && hole != prev_hole) begin
        if (end_reached(walk_idx, walk_hole) && walk_idx < 6) walk_idx++;   // next phase
        check_hole(hole, step_hole(walk_idx, walk_hole), "phase walk step");
        walk_hole = hole;
        walk_steps++;
      end
      prev_working = working;
      prev_hole    = hole;
    end
  end

  initial begin
    while (cycles <= CYCLE_LIMIT) begin
      @(posedge pclk);
      cycles++;
    end
    $display("timeout: tests still running after %0d clock cycles", CYCLE_LIMIT);
    $display("sim failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // handshake helpers and directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic start_run();
    @(negedge pclk);
    check_bit(start_ack, 1'b0, "start_ack low before req");
    start_req = 1'b1;
    @(negedge pclk);
    check_bit(working, 1'b1, "working one cycle after start");
  endtask

  task automatic finish_run();
    int waited;
    waited = 0;
    while (!start_ack && waited < RUN_LIMIT) begin
      @(negedge pclk);
      waited++;
    end
    if (!start_ack) begin
      err_cnt++;
      $display("start_ack did not rise within %0d cycles of start_req", RUN_LIMIT);
    end
    check_bit(working, 1'b0, "working at ack");
    check_hole(hole, FINAL_HOLE, "hole at ack");
    start_req = 1'b0;
    @(negedge pclk);
    check_bit(start_ack, 1'b0, "start_ack one cycle after req drop");
  endtask

  task automatic report_test(string name, int errs);
    tests_run++;
    if (err_cnt == errs) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - errs);
    end
  endtask

  task automatic reset_state();
    int errs;
    errs = err_cnt;
    check_bit(start_ack, 1'b0, "start_ack after reset");
    check_bit(working, 1'b0, "working after reset");
    check_hole(hole, '0, "hole after reset");
    repeat (40) @(negedge pclk);
    check_count(wall_cnt, 0, "walls painted while idle");
    report_test("reset state", errs);
  endtask

  task automatic full_runs();
    int errs;
    errs = err_cnt;
    repeat (2) begin
      start_run();
      finish_run();
    end
    report_test("full runs", errs);
  endtask

  task automatic phase_walk();
    int errs;
    errs = err_cnt;
    start_run();
    finish_run();
    check_count(walk_idx, 6, "last motion phase reached");
    check_count(walk_steps, TOTAL_STEPS, "hole steps in one run");
    check_bit(end_reached(6, walk_hole), 1'b1, "end condition of last phase");
    report_test("phase walk", errs);
  endtask

  task automatic overlay_during_run();
    int errs;
    int walls;
    errs  = err_cnt;
    walls = wall_cnt;
    start_run();
    finish_run();
    check_bit(wall_cnt > walls, 1'b1, "wall pixels seen during run");
    report_test("overlay during run", errs);
  endtask

  task automatic abort_mid_run();
    int errs;
    int walls;
    errs = err_cnt;
    start_run();
    repeat (400) @(negedge pclk);   // about 100 steps into CLOSE_IN
    check_bit(working, 1'b1, "working before abort");
    abort = 1'b1;
    @(negedge pclk);
    abort = 1'b0;
    check_bit(working, 1'b0, "working one cycle after abort");
    repeat (2) begin   // pixels that entered before the abort drain out
      check_bit(start_ack, 1'b0, "start_ack while req held after abort");
      @(negedge pclk);
    end
    walls = wall_cnt;
    repeat (20) begin
      check_bit(start_ack, 1'b0, "start_ack while req held after abort");
      @(negedge pclk);
    end
    check_count(wall_cnt, walls, "walls painted after abort");
    start_req = 1'b0;
    start_run();
    finish_run();
    report_test("abort mid run", errs);
  endtask

  task automatic outside_field();
    int errs;
    int walls;
    errs         = err_cnt;
    walls        = wall_cnt;
    outside_only = 1'b1;
    repeat (40) @(negedge pclk);
    start_run();
    finish_run();
    outside_only = 1'b0;
    check_count(wall_cnt, walls, "walls painted outside field");
    report_test("outside field", errs);
  endtask

  initial begin
    void'($urandom(32'h2716_26ae));
    repeat (8) @(negedge pclk);
    rst       = 1'b0;
    stream_on = 1'b1;
    reset_state();
    full_runs();
    phase_walk();
    overlay_during_run();
    abort_mid_run();
    outside_field();
    $display("tests %0d of %0d passed, %0d errors, %0d pixels checked",
             tests_ok, tests_run, err_cnt, px_checked);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
hdl/video_pkg.sv
hdl/obstacle_pkg.sv
hdl/step_timer.sv
hdl/hole_sequencer.sv
hdl/wall_overlay.sv
hdl/obstacle_top.sv
bench/tb_obstacle.sv

/* Makefile */
TOP = tb_obstacle

all: run

compile:
	verilator --binary --timing -j 0 -f compile.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
